// ==== io_soc.f ====
+incdir+include
hw/io_soc_pkg.sv
hw/io_interconnect.sv
hw/led_core.sv
hw/timer_core.sv
hw/uart_tx_core.sv
hw/io_soc_top.sv
tests/io_soc_tb.sv

// ==== Makefile ====
# Verilator build and run for the I/O subsystem testbench

VERILATOR ?= verilator
TOP       ?= io_soc_tb
FLIST     ?= io_soc.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
	rm -f $(LOG)

// ==== tests/io_soc_tb.sv ====
`timescale 1ns/1ns
`include "io_soc_consts.svh"

module io_soc_tb
    import io_soc_pkg::*;
();
    localparam int LED_COUNT = 4;
    localparam int TX_DIV = 6;
    localparam int BURST_LEN = `UART_FIFO_DEPTH + 2;
    localparam io_data_t LED_MASK = io_data_t'((1 << LED_COUNT) - 1);

    // Slot in address bits 5:4, register in bits 3:2
    localparam io_addr_t LED_REG     = 32'h00;
    localparam io_addr_t TIMER_COUNT = 32'h10;
    localparam io_addr_t TIMER_CTRL  = 32'h14;
    localparam io_addr_t UART_DATA   = 32'h20;
    localparam io_addr_t UART_STATUS = 32'h24;
    localparam io_addr_t UART_DIV    = 32'h28;
    localparam io_addr_t EMPTY_SLOT  = 32'h30;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_SAMPLE,
        OP_READ_DELTA,
        OP_WAIT,
        OP_CHECK_LED,
        OP_WAIT_IDLE
    } op_t;

    typedef struct packed {
        op_t      op;
        io_addr_t addr;
        io_data_t data;
        io_data_t expected;
        int       wait_cycles;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    io_req_t              io_req;
    io_data_t             rd_data;
    logic [LED_COUNT-1:0] led;
    logic                 uart_tx;

    step_t      steps[$];
    uart_byte_t exp_bytes[$];
    uart_byte_t rx_bytes[$];
    int         seed;
    int         bit_div;
    int         mismatch_count = 0;
    int         protocol_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    io_data_t   last_rd;

    io_soc_top #(.LED_COUNT(LED_COUNT)) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .io_req(io_req),
        .rd_data(rd_data),
        .led(led),
        .uart_tx(uart_tx)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_data(input string name, input io_data_t actual,
                              input io_data_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_led(input logic [LED_COUNT-1:0] actual,
                             input logic [LED_COUNT-1:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch led: got %h, expected %h", actual, expected);
        end
    endtask

    task automatic check_byte(input uart_byte_t actual, input uart_byte_t expected,
                              input int index);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch uart_tx byte %0d: got %h, expected %h", index, actual, expected);
        end
    endtask

    task automatic add_step(input op_t op, input io_addr_t addr, input io_data_t data,
                            input io_data_t expected, input int wait_cycles);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.data = data;
        s.expected = expected;
        s.wait_cycles = wait_cycles;
        steps.push_back(s);
    endtask

    task automatic build_steps();
        io_data_t rnd;
        // Reset values of every register
        add_step(OP_READ, LED_REG, '0, '0, 0);
        add_step(OP_READ, TIMER_COUNT, '0, '0, 0);
        add_step(OP_READ, TIMER_CTRL, '0, '0, 0);
        add_step(OP_READ, UART_DATA, '0, '0, 0);
        add_step(OP_READ, UART_STATUS, '0, 32'h2, 0);
        add_step(OP_READ, UART_DIV, '0, `UART_DEFAULT_DIVISOR, 0);
        add_step(OP_READ, EMPTY_SLOT, '0, '0, 0);
        // Upper LED write bits must not read back
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            add_step(OP_WRITE, LED_REG, rnd, '0, 0);
            add_step(OP_CHECK_LED, '0, '0, rnd & LED_MASK, 0);
            add_step(OP_READ, LED_REG, '0, rnd & LED_MASK, 0);
        end
        add_step(OP_READ, EMPTY_SLOT, '0, '0, 0);
        // Timer stopped, then running, then stopped and cleared
        add_step(OP_READ, TIMER_COUNT, '0, '0, 5);
        add_step(OP_READ, TIMER_COUNT, '0, '0, 0);
        add_step(OP_WRITE, TIMER_CTRL, 32'h1, '0, 0);
        add_step(OP_READ, TIMER_CTRL, '0, 32'h1, 0);
        add_step(OP_SAMPLE, TIMER_COUNT, '0, '0, 9);
        add_step(OP_READ_DELTA, TIMER_COUNT, '0, 32'd10, 22);
        add_step(OP_READ_DELTA, TIMER_COUNT, '0, 32'd23, 0);
        add_step(OP_WRITE, TIMER_CTRL, 32'h0, '0, 3);
        add_step(OP_SAMPLE, TIMER_COUNT, '0, '0, 7);
        add_step(OP_READ_DELTA, TIMER_COUNT, '0, 32'd0, 0);
        add_step(OP_WRITE, TIMER_CTRL, 32'h2, '0, 0);
        add_step(OP_READ, TIMER_COUNT, '0, '0, 0);
        add_step(OP_READ, TIMER_CTRL, '0, '0, 2);
        // UART at a new bit rate
        add_step(OP_WRITE, UART_DIV, TX_DIV, '0, 0);
        add_step(OP_READ, UART_DIV, '0, TX_DIV, 0);
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            add_step(OP_WRITE, UART_DATA, rnd, '0, 1);
            exp_bytes.push_back(rnd[7:0]);
        end
        add_step(OP_WAIT_IDLE, UART_STATUS, '0, 32'h2, 2);
        // First byte keeps the transmitter busy while the burst fills the FIFO
        rnd = $random(seed);
        add_step(OP_WRITE, UART_DATA, rnd, '0, 3);
        exp_bytes.push_back(rnd[7:0]);
        for (int i = 0; i < BURST_LEN; i++) begin
            rnd = $random(seed);
            add_step(OP_WRITE, UART_DATA, rnd, '0, 0);
            if (i < `UART_FIFO_DEPTH) begin
                exp_bytes.push_back(rnd[7:0]);
            end
        end
        add_step(OP_READ, UART_STATUS, '0, 32'h1, 0);
        add_step(OP_WAIT_IDLE, UART_STATUS, '0, 32'h2, 0);
        add_step(OP_READ, UART_STATUS, '0, 32'h2, 0);
        add_step(OP_WAIT, '0, '0, '0, 4);
    endtask

    task automatic set_cycle_limit();
        int total;
        total = 0;
        foreach (steps[i]) begin
            total += steps[i].wait_cycles + 1;
        end
        cycle_limit = total + exp_bytes.size() * 12 * TX_DIV + 200;
    endtask

    // Polls the status register until the transmitter is idle with the FIFO empty
    task automatic wait_tx_idle(input io_data_t expected);
        io_data_t status;
        status = '0;
        while (status[1] !== 1'b1) begin
            io_req.rd_en = 1'b1;
            io_req.address = UART_STATUS;
            @(negedge clk);
            io_req = '0;
            status = rd_data;
        end
        check_data("rd_data uart status", status, expected);
    endtask

    task automatic apply_step(input step_t s);
        string name;
        name = $sformatf("rd_data at %h", s.addr);
        case (s.op)
            OP_WRITE, OP_READ, OP_SAMPLE, OP_READ_DELTA: begin
                io_req.rd_en = (s.op != OP_WRITE);
                io_req.wr_en = (s.op == OP_WRITE);
                io_req.address = s.addr;
                io_req.wr_data = s.data;
                if (s.op == OP_WRITE && s.addr == UART_DIV) begin
                    bit_div = int'(s.data[15:0]);
                end
                @(negedge clk);
                io_req = '0;
                if (s.op == OP_READ) begin
                    check_data(name, rd_data, s.expected);
                end else if (s.op == OP_READ_DELTA) begin
                    check_data(name, rd_data, last_rd + s.expected);
                end
                if (s.op != OP_WRITE) begin
                    last_rd = rd_data;
                end
            end
            OP_CHECK_LED: check_led(led, s.expected[LED_COUNT-1:0]);
            OP_WAIT_IDLE: wait_tx_idle(s.expected);
            default: ;
        endcase
        repeat (s.wait_cycles) @(negedge clk);
    endtask

    task automatic compare_bytes();
        if (rx_bytes.size() != exp_bytes.size()) begin
            protocol_count++;
            $display("uart_tx carried %0d bytes where %0d were expected",
                     rx_bytes.size(), exp_bytes.size());
        end
        foreach (exp_bytes[i]) begin
            if (i < rx_bytes.size()) begin
                check_byte(rx_bytes[i], exp_bytes[i], i);
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
    endtask

    // Serial receiver sampling each bit near its middle
    initial begin : uart_monitor
        uart_byte_t rx;
        int         bit_len;
        rx = '0;
        forever begin
            @(negedge uart_tx);
            bit_len = bit_div;
            repeat (bit_len / 2) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                protocol_count++;
                $display("start bit on uart_tx was not low at %0t", $time);
            end
            for (int b = 0; b < 8; b++) begin
                repeat (bit_len) @(negedge clk);
                rx[b] = uart_tx;
            end
            repeat (bit_len) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                protocol_count++;
                $display("stop bit on uart_tx was not high at %0t", $time);
            end
            rx_bytes.push_back(rx);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            protocol_count++;
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        io_req = '0;
        rst_n = 1'b0;
        seed = 32'h9603da0c;
        bit_div = `UART_DEFAULT_DIVISOR;
        last_rd = '0;
        build_steps();
        set_cycle_limit();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_led(led, '0);
        check_data("uart_tx", io_data_t'(uart_tx), 32'h1);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        compare_bytes();
        report_counts();
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/io_soc_top.sv ====
`timescale 1ns/1ns

module io_soc_top
    import io_soc_pkg::*;
#(
    parameter int LED_COUNT = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  io_req_t              io_req,
    output io_data_t             rd_data,
    output logic [LED_COUNT-1:0] led,
    output logic                 uart_tx
);
    io_cs_t   cs;
    logic     led_sel;
    logic     timer_sel;
    logic     uart_sel;
    io_data_t led_rd_data;
    io_data_t timer_rd_data;
    io_data_t uart_rd_data;

    assign led_sel   = cs[0];
    assign timer_sel = cs[1];
    assign uart_sel  = cs[2];

    io_interconnect io_xbar (
        .clk(clk),
        .rst_n(rst_n),
        .io_req(io_req),
        .cs(cs),
        .led_rd_data(led_rd_data),
        .timer_rd_data(timer_rd_data),
        .uart_rd_data(uart_rd_data),
        .rd_data(rd_data)
    );

    // Slot 0
    led_core #(.LED_COUNT(LED_COUNT)) ledc (
        .clk(clk),
        .rst_n(rst_n),
        .io_req(io_req),
        .sel(led_sel),
        .rd_data(led_rd_data),
        .led(led)
    );

    // Slot 1
    timer_core timer (
        .clk(clk),
        .rst_n(rst_n),
        .io_req(io_req),
        .sel(timer_sel),
        .rd_data(timer_rd_data)
    );

    // Slot 2
    uart_tx_core uart (
        .clk(clk),
        .rst_n(rst_n),
        .io_req(io_req),
        .sel(uart_sel),
        .rd_data(uart_rd_data),
        .uart_tx(uart_tx)
    );

endmodule

// ==== hw/uart_tx_core.sv ====
`timescale 1ns/1ns
`include "io_soc_consts.svh"

module uart_tx_core
    import io_soc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  io_req_t  io_req,
    input  logic     sel,
    output io_data_t rd_data,
    output logic     uart_tx
);
    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

    io_reg_t     reg_idx;
    uart_byte_t  fifo_mem [`UART_FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;
    uart_div_t   divisor;
    uart_div_t   baud_cnt;
    logic        bit_end;
    logic [2:0]  bit_idx;
    uart_byte_t  shift_reg;
    uart_state_t state;

    assign reg_idx = io_req.address[`IO_REG_LSB +: $bits(io_reg_t)];

    // Extra pointer bit tells full from empty
    assign empty = wr_ptr == rd_ptr;
    assign full  = wr_ptr[PTR_W] != rd_ptr[PTR_W] && wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0];

    // Writes to a full FIFO are dropped
    assign push = sel && io_req.wr_en && reg_idx == 2'd0 && !full;
    assign pop  = state == tx_idle && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr[PTR_W-1:0]] <= io_req.wr_data[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            divisor <= uart_div_t'(`UART_DEFAULT_DIVISOR);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (sel && io_req.wr_en && reg_idx == 2'd2) begin
                divisor <= io_req.wr_data[15:0];
            end
        end
    end

    assign bit_end = baud_cnt == divisor - 16'd1;

    // Start bit, 8 data bits LSB first, stop bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= tx_idle;
            uart_tx  <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            baud_cnt <= bit_end ? 16'd0 : baud_cnt + 16'd1;
            case (state)
                tx_idle: begin
                    baud_cnt <= '0;
                    if (pop) begin
                        shift_reg <= fifo_mem[rd_ptr[PTR_W-1:0]];
                        uart_tx   <= 1'b0;
                        state     <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        uart_tx   <= shift_reg[0];
                        shift_reg <= shift_reg >> 1;
                        bit_idx   <= '0;
                        state     <= tx_data;
                    end
                end
                tx_data: begin
                    if (bit_end && bit_idx == 3'd7) begin
                        uart_tx <= 1'b1;
                        state   <= tx_stop;
                    end else if (bit_end) begin
                        uart_tx   <= shift_reg[0];
                        shift_reg <= shift_reg >> 1;
                        bit_idx   <= bit_idx + 3'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            2'd1:    rd_data = {30'd0, state == tx_idle && empty, full};
            2'd2:    rd_data = {16'd0, divisor};
            default: rd_data = '0;
        endcase
    end

endmodule

// ==== hw/timer_core.sv ====
`timescale 1ns/1ns
`include "io_soc_consts.svh"

module timer_core
    import io_soc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  io_req_t  io_req,
    input  logic     sel,
    output io_data_t rd_data
);
    localparam io_reg_t REG_COUNT = 2'd0;
    localparam io_reg_t REG_CTRL  = 2'd1;

    io_reg_t  reg_idx;
    logic     ctrl_wr;
    logic     clear;
    logic     enable;
    io_data_t count;

    assign reg_idx = io_req.address[`IO_REG_LSB +: $bits(io_reg_t)];
    assign ctrl_wr = sel && io_req.wr_en && reg_idx == REG_CTRL;

    // Bit 1 of a control write zeroes the count
    assign clear = ctrl_wr && io_req.wr_data[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (ctrl_wr) begin
            enable <= io_req.wr_data[0];
        end
    end

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 32'd1;
        end
    end

    always_comb begin
        case (reg_idx)
            REG_COUNT: rd_data = count;
            REG_CTRL:  rd_data = {31'd0, enable};
            default:   rd_data = '0;
        endcase
    end

endmodule

// ==== hw/led_core.sv ====
`timescale 1ns/1ns
`include "io_soc_consts.svh"

module led_core
    import io_soc_pkg::*;
#(
    parameter int LED_COUNT = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  io_req_t              io_req,
    input  logic                 sel,
    output io_data_t             rd_data,
    output logic [LED_COUNT-1:0] led
);
    io_reg_t reg_idx;

    assign reg_idx = io_req.address[`IO_REG_LSB +: $bits(io_reg_t)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= '0;
        end else if (sel && io_req.wr_en && reg_idx == 2'd0) begin
            led <= io_req.wr_data[LED_COUNT-1:0];
        end
    end

    // Pattern reads back in the low bits
    always_comb begin
        rd_data = '0;
        if (reg_idx == 2'd0) begin
            rd_data[LED_COUNT-1:0] = led;
        end
    end

endmodule

// ==== hw/io_interconnect.sv ====
`timescale 1ns/1ns
`include "io_soc_consts.svh"

module io_interconnect
    import io_soc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  io_req_t  io_req,
    output io_cs_t   cs,
    input  io_data_t led_rd_data,
    input  io_data_t timer_rd_data,
    input  io_data_t uart_rd_data,
    output io_data_t rd_data
);
    io_slot_t slot;
    io_data_t slot_rd_data;

    assign slot = io_req.address[`IO_SLOT_LSB +: $bits(io_slot_t)];

    // One-hot select from the slot field
    always_comb begin
        cs = '0;
        cs[slot] = 1'b1;
    end

    always_comb begin
        case (slot)
            2'd0: slot_rd_data = led_rd_data;
            2'd1: slot_rd_data = timer_rd_data;
            2'd2: slot_rd_data = uart_rd_data;
            // Slot 3 is empty
            default: slot_rd_data = '0;
        endcase
    end

    // Read data is held until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (io_req.rd_en) begin
            rd_data <= slot_rd_data;
        end
    end

endmodule

// ==== hw/io_soc_pkg.sv ====
`include "io_soc_consts.svh"

package io_soc_pkg;

    typedef logic [31:0] io_addr_t;
    typedef logic [31:0] io_data_t;
    typedef logic [1:0] io_slot_t;
    typedef logic [1:0] io_reg_t;
    typedef logic [`IO_NUM_SLOTS-1:0] io_cs_t;

    // One request from the bus master
    typedef struct packed {
        logic     rd_en;
        logic     wr_en;
        io_addr_t address;
        io_data_t wr_data;
    } io_req_t;

    typedef logic [7:0] uart_byte_t;
    typedef logic [15:0] uart_div_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_state_t;

endpackage

// ==== include/io_soc_consts.svh ====
`ifndef IO_SOC_CONSTS_SVH
`define IO_SOC_CONSTS_SVH

// I/O slot map
`define IO_NUM_SLOTS 4

// Address bits 5:4 pick the slot
`define IO_SLOT_LSB 4

// Address bits 3:2 pick the register of a word-aligned access
`define IO_REG_LSB 2

// UART transmitter
`define UART_FIFO_DEPTH 4

// Clock cycles per serial bit out of reset
`define UART_DEFAULT_DIVISOR 8

`endif
